//--- design/msoc_pkg.sv
// Shared widths, region codes and the bus request type for the data bus.
// Region codes come from address bits 23:20 and board offsets from bits 5:2.
// Only regions 1, 3 and 7 are mapped; every other code reads as zero.
`default_nettype none

package msoc_pkg;

  //////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////

  localparam int msoc_addr_w   = 32;
  localparam int msoc_data_w   = 32;
  localparam int msoc_be_w     = msoc_data_w / 8; // one enable per byte lane
  localparam int msoc_region_w = 4;               // addr[23:20]
  localparam int msoc_reg_w    = 4;               // addr[5:2]

  //////////////////////////////////////////////////////////////
  // address map codes
  //////////////////////////////////////////////////////////////

  typedef enum logic [msoc_region_w-1:0] {
    region_ram   = 4'd1, // data ram
    region_uart  = 4'd3, // receive fifo window
    region_board = 4'd7  // leds and dip switches
  } msoc_region_e;

  typedef enum logic [msoc_reg_w-1:0] {
    board_led_dip = 4'd0, // write led, read dip
    board_led_rd  = 4'd1  // read back led
  } msoc_board_reg_e;

  //////////////////////////////////////////////////////////////
  // request bundle from the bus master
  //////////////////////////////////////////////////////////////

  // 69 bits, qualified by req
  typedef struct packed {
    logic [msoc_addr_w-1:0] addr;
    logic [msoc_data_w-1:0] wdata;
    logic [msoc_be_w-1:0]   be;
    logic                   we;
  } msoc_bus_req_t;

endpackage

`default_nettype wire

//--- design/msoc_bus_ctrl.sv
// Data bus controller: decodes the region, grants every request at once
// and returns one response exactly one cycle later.
// Targets never stall, so gnt_o simply follows req_i.
// Write responses and unmapped regions carry zero data.
`default_nettype none

module msoc_bus_ctrl
  (
  input  wire logic                              msoc_clk,
  input  wire logic                              rstn,
  // master side
  input  wire logic                              req_i,
  input  wire msoc_pkg::msoc_bus_req_t           bus_req_i,
  output logic                                   gnt_o,
  output logic                                   rvalid_o,
  output logic [msoc_pkg::msoc_data_w-1:0]       rdata_o,
  // target side
  output logic                                   ram_sel_o,
  output logic                                   periph_sel_o,
  output msoc_pkg::msoc_region_e                 region_o,
  input  wire logic [msoc_pkg::msoc_data_w-1:0]  ram_rdata_i,
  input  wire logic [msoc_pkg::msoc_data_w-1:0]  periph_rdata_i
  );

  import msoc_pkg::*;

  localparam int n_regions = 2 ** msoc_region_w;

  logic [n_regions-1:0] region_hot; // one bit per address region
  logic                 rvalid_q;
  logic                 resp_ram_q;    // read response comes from ram
  logic                 resp_periph_q; // read response comes from periph

  //////////////////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////////////////

  assign region_o = msoc_region_e'(bus_req_i.addr[23:20]);

  always_comb
  begin
    for (int i = 0; i < n_regions; i++)
    begin
      region_hot[i] = (bus_req_i.addr[23:20] == msoc_region_w'(i));
    end
  end

  assign gnt_o        = req_i; // no back-pressure
  assign ram_sel_o    = req_i & region_hot[region_ram];
  assign periph_sel_o = req_i & (region_hot[region_uart] | region_hot[region_board]);

  //////////////////////////////////////////////////////////////
  // response register
  //////////////////////////////////////////////////////////////

  // one response slot, refilled every cycle a request is granted
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rvalid_q      <= 1'b0;
      resp_ram_q    <= 1'b0;
      resp_periph_q <= 1'b0;
    end
    else
    begin
      rvalid_q      <= req_i;
      resp_ram_q    <= ram_sel_o & ~bus_req_i.we;    // reads only
      resp_periph_q <= periph_sel_o & ~bus_req_i.we;
    end
  end

  assign rvalid_o = rvalid_q;

  //////////////////////////////////////////////////////////////
  // read data combining
  //////////////////////////////////////////////////////////////

  always_comb
  begin
    rdata_o = '0; // writes and unmapped regions
    if (resp_ram_q)
    begin
      rdata_o = ram_rdata_i;
    end
    else if (resp_periph_q)
    begin
      rdata_o = periph_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- design/msoc_data_ram.sv
// Byte-enabled word RAM with a one-cycle registered read.
// The word index is address bits 15:2 taken modulo ram_words.
// Read data holds its last value when no read is selected.
`default_nettype none

module msoc_data_ram
  #(
  parameter int ram_words = 1024
  )
  (
  input  wire logic                        msoc_clk,
  input  wire logic                        sel_i,
  input  wire msoc_pkg::msoc_bus_req_t     bus_req_i,
  output logic [msoc_pkg::msoc_data_w-1:0] rdata_o
  );

  import msoc_pkg::*;

  localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;

  logic [msoc_data_w-1:0] mem [ram_words];
  logic [idx_w-1:0]       word_idx;

  // wraps for any depth, not just powers of two
  assign word_idx = idx_w'(32'(bus_req_i.addr[15:2]) % ram_words);

  always_ff @(posedge msoc_clk)
  begin
    if (sel_i && bus_req_i.we)
    begin
      for (int b = 0; b < msoc_be_w; b++)
      begin
        if (bus_req_i.be[b])
          mem[word_idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8]; // merge lane
      end
    end
    else if (sel_i)
    begin
      rdata_o <= mem[word_idx]; // registered read
    end
  end

endmodule

`default_nettype wire

//--- design/msoc_periph_regs.sv
// Receive FIFO, LED register and DIP sample register behind the bus.
// rx_depth must be a power of two and at least 2; the count field is 4 bits.
// Bytes arriving while full are dropped and set a sticky overflow flag.
// Only offset 0 of the receive window is decoded.
`default_nettype none

module msoc_periph_regs
  #(
  parameter int rx_depth = 8
  )
  (
  input  wire logic                        msoc_clk,
  input  wire logic                        rstn,
  // bus side
  input  wire logic                        sel_i,
  input  wire msoc_pkg::msoc_region_e      region_i,
  input  wire msoc_pkg::msoc_bus_req_t     bus_req_i,
  output logic [msoc_pkg::msoc_data_w-1:0] rdata_o,
  // receive byte stream
  input  wire logic                        rx_valid_i,
  input  wire logic [7:0]                  rx_byte_i,
  // board i/o
  input  wire logic [15:0]                 dip_i,
  output logic [7:0]                       led_o
  );

  import msoc_pkg::*;

  localparam int ptr_w = $clog2(rx_depth);
  localparam int cnt_w = ptr_w + 1;

  logic [7:0]             rx_mem [rx_depth];
  logic [ptr_w-1:0]       wr_ptr, rd_ptr;
  logic [cnt_w-1:0]       rx_count;
  logic                   rx_overflow;
  logic                   rx_empty, rx_full;
  logic                   rx_push, rx_pop;
  logic [7:0]             rx_head;
  logic                   uart_hit, board_hit;
  msoc_board_reg_e        board_reg;
  logic [7:0]             led_q;
  logic [15:0]            dip_q;
  logic [msoc_data_w-1:0] rd_word;

  assign uart_hit  = sel_i && (region_i == region_uart) && (bus_req_i.addr[5:2] == 4'd0);
  assign board_hit = sel_i && (region_i == region_board);
  assign board_reg = msoc_board_reg_e'(bus_req_i.addr[5:2]);

  //////////////////////////////////////////////////////////////
  // receive fifo
  //////////////////////////////////////////////////////////////

  assign rx_empty = (rx_count == '0);
  assign rx_full  = (rx_count == cnt_w'(rx_depth));
  assign rx_push  = rx_valid_i & ~rx_full;               // drop when full
  assign rx_pop   = uart_hit & bus_req_i.we & ~rx_empty; // write pops
  assign rx_head  = rx_empty ? 8'h00 : rx_mem[rd_ptr];

  always_ff @(posedge msoc_clk)
  begin
    if (rx_push)
      rx_mem[wr_ptr] <= rx_byte_i;
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      rx_count    <= '0;
      rx_overflow <= 1'b0;
    end
    else
    begin
      if (rx_push)
        wr_ptr <= wr_ptr + 1'b1; // wraps at rx_depth
      if (rx_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({rx_push, rx_pop})
        2'b10:   rx_count <= rx_count + 1'b1;
        2'b01:   rx_count <= rx_count - 1'b1;
        default: rx_count <= rx_count; // idle or push with pop
      endcase
      if (rx_valid_i && rx_full)
        rx_overflow <= 1'b1; // sticky until reset
    end
  end

  //////////////////////////////////////////////////////////////
  // board registers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_q <= '0;
      dip_q <= '0;
    end
    else
    begin
      dip_q <= dip_i; // sampled every cycle
      if (board_hit && bus_req_i.we && (board_reg == board_led_dip))
        led_q <= bus_req_i.wdata[7:0];
    end
  end

  assign led_o = led_q;

  //////////////////////////////////////////////////////////////
  // read word select
  //////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_word = '0;
    if (uart_hit)
    begin
      rd_word = {16'h0000, 4'(rx_count), 1'b0, rx_overflow, rx_full, ~rx_empty, rx_head};
    end
    else if (board_hit)
    begin
      case (board_reg)
        board_led_dip: rd_word = {16'h0000, dip_q};
        board_led_rd:  rd_word = {24'h000000, led_q};
        default:       rd_word = '0;
      endcase
    end
  end

  // state seen in the request cycle, presented one cycle later
  always_ff @(posedge msoc_clk)
  begin
    if (sel_i && !bus_req_i.we)
      rdata_o <= rd_word;
  end

endmodule

`default_nettype wire

//--- design/msoc_bus_top.sv
// Data bus subsystem: controller, data RAM and peripheral registers.
// Received bytes enter as a byte plus strobe; there is no serial line here.
// ram_words and rx_depth are set here and passed down.
`default_nettype none

module msoc_bus_top
  #(
  parameter int ram_words = 1024,
  parameter int rx_depth  = 8
  )
  (
  input  wire logic                        msoc_clk,
  input  wire logic                        rstn,
  input  wire logic                        req_i,
  input  wire msoc_pkg::msoc_bus_req_t     bus_req_i,
  output logic                             gnt_o,
  output logic                             rvalid_o,
  output logic [msoc_pkg::msoc_data_w-1:0] rdata_o,
  input  wire logic                        rx_valid_i,
  input  wire logic [7:0]                  rx_byte_i,
  input  wire logic [15:0]                 dip_i,
  output logic [7:0]                       led_o
  );

  import msoc_pkg::*;

  logic                   ram_sel;
  logic                   periph_sel;
  msoc_region_e           region;
  logic [msoc_data_w-1:0] ram_rdata;
  logic [msoc_data_w-1:0] periph_rdata;

  msoc_bus_ctrl u_bus_ctrl (
    .msoc_clk       (msoc_clk),
    .rstn           (rstn),
    .req_i          (req_i),
    .bus_req_i      (bus_req_i),
    .gnt_o          (gnt_o),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .ram_sel_o      (ram_sel),
    .periph_sel_o   (periph_sel),
    .region_o       (region),
    .ram_rdata_i    (ram_rdata),
    .periph_rdata_i (periph_rdata)
  );

  msoc_data_ram #(.ram_words(ram_words)) u_data_ram (
    .msoc_clk  (msoc_clk),
    .sel_i     (ram_sel),
    .bus_req_i (bus_req_i),
    .rdata_o   (ram_rdata)
  );

  msoc_periph_regs #(.rx_depth(rx_depth)) u_periph_regs (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .sel_i      (periph_sel),
    .region_i   (region),
    .bus_req_i  (bus_req_i),
    .rdata_o    (periph_rdata),
    .rx_valid_i (rx_valid_i),
    .rx_byte_i  (rx_byte_i),
    .dip_i      (dip_i),
    .led_o      (led_o)
  );

endmodule

`default_nettype wire

//--- verification/msoc_clk_gen.sv
// Free-running 20 ns clock and an active-low reset held for 4 rising edges.
// Reset is released with a nonblocking update on a rising edge.
`default_nettype none

module msoc_clk_gen
  #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 4
  )
  (
  output logic msoc_clk,
  output logic rstn
  );
  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    msoc_clk = 1'b0;
    forever #(half_period) msoc_clk = ~msoc_clk;
  end

  initial
  begin
    rstn = 1'b0;
    repeat (reset_cycles) @(posedge msoc_clk);
    rstn <= 1'b1; // released on the 4th rising edge
  end

endmodule

`default_nettype wire

//--- verification/msoc_bus_sva.sv
// Handshake and LED register checks, bound into msoc_bus_top.
// Assumes every target answers in one cycle, as the controller never stalls.
`default_nettype none

module msoc_bus_sva
  (
  input wire logic                    msoc_clk,
  input wire logic                    rstn,
  input wire logic                    req_i,
  input wire msoc_pkg::msoc_bus_req_t bus_req_i,
  input wire logic                    gnt_o,
  input wire logic                    rvalid_o,
  input wire logic [7:0]              led_o
  );
  timeunit 1ns;
  timeprecision 1ps;

  import msoc_pkg::*;

  logic board_wr; // granted write to the led register

  assign board_wr = req_i && gnt_o && bus_req_i.we
                    && (bus_req_i.addr[23:20] == region_board)
                    && (bus_req_i.addr[5:2] == board_led_dip);

  gnt_follows_req: assert property (@(posedge msoc_clk) disable iff (!rstn)
    gnt_o == req_i) else $error("gnt_o does not follow req_i");

  rvalid_after_grant: assert property (@(posedge msoc_clk) disable iff (!rstn)
    (req_i && gnt_o) |=> rvalid_o) else $error("no rvalid_o one cycle after a grant");

  no_stray_rvalid: assert property (@(posedge msoc_clk) disable iff (!rstn)
    !(req_i && gnt_o) |=> !rvalid_o) else $error("rvalid_o without a grant");

  led_only_on_write: assert property (@(posedge msoc_clk) disable iff (!rstn)
    !$stable(led_o) |-> $past(board_wr)) else $error("led_o changed without a write");

endmodule

bind msoc_bus_top msoc_bus_sva u_bus_sva (
  .msoc_clk  (msoc_clk),
  .rstn      (rstn),
  .req_i     (req_i),
  .bus_req_i (bus_req_i),
  .gnt_o     (gnt_o),
  .rvalid_o  (rvalid_o),
  .led_o     (led_o)
);

`default_nettype wire

//--- verification/msoc_tb.sv
// Random data bus and receive traffic checked against a reference model.
// ram_words and rx_depth here must match what the DUT is built with.
// Only the low 64 RAM words are used; the run stops at the first error.
`default_nettype none

module msoc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import msoc_pkg::*;

  localparam int ram_words = 1024;
  localparam int rx_depth  = 8;
  localparam int n_random  = 600;

  logic          msoc_clk;
  logic          rstn;
  logic          req_i;
  msoc_bus_req_t bus_req_i;
  logic          gnt_o;
  logic          rvalid_o;
  logic [31:0]   rdata_o;
  logic          rx_valid_i;
  logic [7:0]    rx_byte_i;
  logic [15:0]   dip_i;
  logic [7:0]    led_o;

  logic [31:0]   ram_model [64];
  logic [7:0]    rx_model [$];
  logic          ovf_model;
  logic [7:0]    led_model;
  logic [15:0]   dip_model;     // value the dut has registered
  logic [31:0]   exp_data_q [$]; // responses still owed
  int            exp_cyc_q [$];
  string         exp_name_q [$];
  int            cyc = 0;
  int            seed;

  msoc_clk_gen u_clk_gen (.msoc_clk(msoc_clk), .rstn(rstn));

  msoc_bus_top #(.ram_words(ram_words), .rx_depth(rx_depth)) dut_i (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .req_i      (req_i),
    .bus_req_i  (bus_req_i),
    .gnt_o      (gnt_o),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o),
    .rx_valid_i (rx_valid_i),
    .rx_byte_i  (rx_byte_i),
    .dip_i      (dip_i),
    .led_o      (led_o)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      fail_run($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                         name, expected, actual));
  endtask

  function automatic logic [31:0] bus_addr(input logic [3:0] region, input logic [5:0] idx);
    return {8'h00, region, 12'h000, idx, 2'b00};
  endfunction

  function automatic string region_name(input logic [3:0] region);
    case (region)
      4'd1:    return "ram";
      4'd3:    return "rx_fifo";
      4'd7:    return "board";
      default: return "unmapped";
    endcase
  endfunction

  // head byte, not-empty, full, overflow and count fields
  function automatic logic [31:0] rx_status();
    logic [7:0] head;
    head = (rx_model.size() == 0) ? 8'h00 : rx_model[0];
    return {16'h0000, 4'(rx_model.size()), 1'b0, ovf_model,
            rx_model.size() == rx_depth, rx_model.size() != 0, head};
  endfunction

  // one clock cycle of bus request, receive strobe and dip value
  task automatic drive_cycle(input logic do_req, input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             input logic rx_v, input logic [7:0] rx_b,
                             input logic [15:0] dip, input string name);
    logic [31:0] expect_val;
    logic [5:0]  idx;
    logic        was_empty;
    logic        was_full;
    int          b;
    @(posedge msoc_clk);
    #2;
    check_equal("led_o", {24'h000000, led_model}, {24'h000000, led_o});
    idx        = addr[7:2];
    was_empty  = (rx_model.size() == 0);
    was_full   = (rx_model.size() == rx_depth);
    expect_val = 32'h0; // writes and unmapped reads
    if (do_req && !we)
    begin
      case (addr[23:20])
        4'd1: expect_val = ram_model[idx];
        4'd3: expect_val = (idx[3:0] == 4'd0) ? rx_status() : 32'h0;
        4'd7:
          if (idx[3:0] == 4'd0)
            expect_val = {16'h0000, dip_model};
          else if (idx[3:0] == 4'd1)
            expect_val = {24'h000000, led_model};
        default: expect_val = 32'h0;
      endcase
    end
    req_i      = do_req;
    bus_req_i  = '{addr: addr, wdata: wdata, be: be, we: we};
    rx_valid_i = rx_v;
    rx_byte_i  = rx_b;
    dip_i      = dip;
    #1;
    check_equal({name, " gnt_o"}, {31'h0, do_req}, {31'h0, gnt_o});
    // state after the coming edge
    if (do_req && we && addr[23:20] == 4'd1)
      for (b = 0; b < 4; b++)
        if (be[b])
          ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
    if (do_req && we && addr[23:20] == 4'd3 && idx[3:0] == 4'd0 && !was_empty)
      void'(rx_model.pop_front());
    if (do_req && we && addr[23:20] == 4'd7 && idx[3:0] == 4'd0)
      led_model = wdata[7:0];
    if (rx_v && !was_full)
      rx_model.push_back(rx_b);
    if (rx_v && was_full)
      ovf_model = 1'b1; // byte dropped
    dip_model = dip;
    if (do_req)
    begin
      exp_data_q.push_back(expect_val);
      exp_cyc_q.push_back(cyc + 1);
      exp_name_q.push_back(name);
    end
  endtask

  task automatic wait_responses(output logic drained);
    int t;
    t = 0;
    while (exp_data_q.size() != 0 && t < 10)
    begin
      drive_cycle(1'b0, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0, 8'h00, dip_model, "drain");
      t++;
    end
    drained = (exp_data_q.size() == 0);
  endtask

  always @(posedge msoc_clk)
    cyc <= cyc + 1;

  // responses are stable by the falling edge
  always @(negedge msoc_clk)
  begin
    if (rstn && rvalid_o)
    begin
      if (exp_data_q.size() == 0)
        fail_run("rvalid_o was raised with no request outstanding");
      else
      begin
        check_equal({exp_name_q[0], " response cycle"}, exp_cyc_q[0], cyc);
        check_equal(exp_name_q[0], exp_data_q[0], rdata_o);
        void'(exp_data_q.pop_front());
        void'(exp_cyc_q.pop_front());
        void'(exp_name_q.pop_front());
      end
    end
    else if (rstn && exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc)
      fail_run("rvalid_o did not arrive one cycle after a grant");
  end

  initial
  begin
    logic [31:0] r;
    logic [31:0] wd;
    logic [3:0]  region;
    logic [5:0]  idx;
    logic        drained;
    int          i;
    int          t;
    seed       = 14;
    req_i      = 1'b0;
    bus_req_i  = '0;
    rx_valid_i = 1'b0;
    rx_byte_i  = 8'h00;
    dip_i      = 16'h0000;
    ovf_model  = 1'b0;
    led_model  = 8'h00;
    dip_model  = 16'h0000;
    t = 0;
    while (rstn !== 1'b1 && t < 20)
    begin
      @(posedge msoc_clk);
      t++;
    end
    if (rstn !== 1'b1)
      fail_run("rstn was never released");
    for (i = 0; i < 64; i++)
      drive_cycle(1'b1, 1'b1, bus_addr(4'd1, 6'(i)), $random(seed), 4'hF,
                  1'b0, 8'h00, dip_model, "ram_fill");

    ////////////////////////////////////////////////////////////
    // random mix, one request per cycle
    ////////////////////////////////////////////////////////////
    for (i = 0; i < n_random; i++)
    begin
      r  = $random(seed);
      wd = $random(seed);
      case (r[2:0])
        3'd0, 3'd1: region = 4'd1;
        3'd2, 3'd3: region = 4'd3;
        3'd4, 3'd5: region = 4'd7;
        default:    region = r[13:10];
      endcase
      if (r[2:0] > 3'd5 && (region == 4'd1 || region == 4'd3 || region == 4'd7))
        region = region + 4'd1; // keep it unmapped
      idx = (region == 4'd7) ? {4'd0, r[9:8]} : (region == 4'd3) ? 6'd0 : r[19:14];
      drive_cycle(r[2:0] != 3'd7, r[3], bus_addr(region, idx), wd, r[7:4],
                  r[23:20] == 4'd0, r[31:24], wd[31:16] ^ wd[15:0], region_name(region));
    end

    ////////////////////////////////////////////////////////////
    // overflow, then drain past empty
    ////////////////////////////////////////////////////////////
    for (i = 0; i < rx_depth + 3; i++)
      drive_cycle(1'b0, 1'b0, 32'h0, 32'h0, 4'h0, 1'b1, 8'hA0 + 8'(i),
                  dip_model, "rx_overflow");
    for (i = 0; i < rx_depth + 2; i++)
    begin
      drive_cycle(1'b1, 1'b0, bus_addr(4'd3, 6'd0), 32'h0, 4'h0, 1'b0, 8'h00,
                  dip_model, "rx_overflow");
      drive_cycle(1'b1, 1'b1, bus_addr(4'd3, 6'd0), 32'h0, 4'h0, 1'b0, 8'h00,
                  dip_model, "rx_pop");
    end
    drive_cycle(1'b1, 1'b0, bus_addr(4'd3, 6'd0), 32'h0, 4'h0, 1'b0, 8'h00,
                dip_model, "rx_overflow");
    wait_responses(drained);
    if (drained)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
      fail_run("timed out after 10 cycles waiting for rvalid_o");
  end

endmodule

`default_nettype wire

//--- msoc_bus.f
design/msoc_pkg.sv
design/msoc_bus_ctrl.sv
design/msoc_data_ram.sv
design/msoc_periph_regs.sv
design/msoc_bus_top.sv
verification/msoc_clk_gen.sv
verification/msoc_bus_sva.sv
verification/msoc_tb.sv

//--- Makefile
# Verilator build and run for the msoc data bus testbench.
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= msoc_tb
FILELIST  ?= msoc_bus.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST RESULT: PASS

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
